// ==== flist.f ====
+incdir+include
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_regfile.sv
logic/rv_apb_port.sv
logic/rv_core_top.sv
tests/rv_core_tb.sv

// ==== include/rv_consts.svh ====
// rv32i subset opcodes, funct codes, data memory depth and apb address map
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// major opcodes, instr[6:0]
`define RV_OP_LUI       7'b0110111
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011

// funct3, instr[14:12]
`define RV_F3_ADD       3'b000      // add, addi, sub
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_XOR       3'b100
`define RV_F3_SRL       3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111
`define RV_F3_LW        3'b010
`define RV_F3_SW        3'b010
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001

`define RV_F7_SUB       7'b0100000  // funct7 of sub

`define RV_DMEM_WORDS   16          // data memory depth in words

// apb byte addresses
`define RV_ADDR_ISSUE       12'h000
`define RV_ADDR_PC          12'h004
`define RV_ADDR_BRCNT       12'h008
`define RV_ADDR_REG_BASE    12'h080 // x0..x31 follow as words

`endif

// ==== logic/rv_apb_port.sv ====
// rv_apb_port: apb3 slave, issue strobe, pc and branch counter, readback mux
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_apb_port (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [11:0]       paddr,
    input  rv_pkg::word_t     pwdata,
    output rv_pkg::word_t     prdata,
    output logic              pready,
    output logic              pslverr,
    output rv_pkg::instr_t    instr,
    output logic              issue,
    input  rv_pkg::dec_t      dec,
    output rv_pkg::reg_addr_t rport,
    input  rv_pkg::word_t     rpdata
);

    import rv_pkg::*;

    logic  access;
    logic  reg_hit;
    word_t pc;
    word_t brcnt;

    assign access  = psel & penable;                            // access phase
    assign issue   = access & pwrite & (paddr == `RV_ADDR_ISSUE);
    assign instr   = issue ? pwdata : '0;                       // quiet bus otherwise
    assign reg_hit = (paddr & 12'hf83) == `RV_ADDR_REG_BASE;    // 0x080..0x0fc, aligned
    assign rport   = paddr[6:2];
    assign pready  = 1'b1;                                      // no wait states

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            if (pwrite) begin
                pslverr = issue ? dec.illegal : 1'b1;           // only issue is writable
            end else if (paddr == `RV_ADDR_PC) begin
                prdata = pc;
            end else if (paddr == `RV_ADDR_BRCNT) begin
                prdata = brcnt;
            end else if (reg_hit) begin
                prdata = rpdata;
            end else begin
                pslverr = 1'b1;                                 // unmapped read
            end
        end
    end

    // retire on the edge closing the issue access
    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= '0;
            brcnt <= '0;
        end else if (issue && !dec.illegal) begin
            pc <= dec.branch_taken ? pc + dec.imm : pc + 32'd4; // imm holds b offset
            if (dec.branch_taken) begin
                brcnt <= brcnt + 32'd1;
            end
        end
    end

    penable_needs_psel: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> psel);

endmodule : rv_apb_port

`default_nettype wire

// ==== logic/rv_core_top.sv ====
// rv_core_top: apb port, decode, register file, execute and result wired together
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic          clk,
    input  logic          reset,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [11:0]   paddr,
    input  rv_pkg::word_t pwdata,
    output rv_pkg::word_t prdata,
    output logic          pready,
    output logic          pslverr
);

    import rv_pkg::*;

    instr_t    instr;
    logic      issue;
    dec_t      dec;
    exe_t      exe;
    word_t     rd1;
    word_t     rd2;
    reg_addr_t rport;
    word_t     rpdata;
    word_t     wb_data;
    reg_addr_t wb_addr;
    logic      wb_en;

    rv_apb_port u_rv_apb_port (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .instr   (instr),
        .issue   (issue),
        .dec     (dec),
        .rport   (rport),
        .rpdata  (rpdata)
    );

    rv_decode u_rv_decode (
        .instr (instr),
        .rd1   (rd1),
        .rd2   (rd2),
        .dec   (dec)
    );

    rv_regfile u_rv_regfile (
        .clk    (clk),
        .reset  (reset),
        .ra1    (dec.ra1),
        .ra2    (dec.ra2),
        .rport  (rport),
        .rd1    (rd1),
        .rd2    (rd2),
        .rpdata (rpdata),
        .wa     (wb_addr),
        .we     (wb_en),
        .wd     (wb_data)
    );

    rv_execute u_rv_execute (
        .dec (dec),
        .rd1 (rd1),
        .rd2 (rd2),
        .exe (exe)
    );

    rv_result u_rv_result (
        .clk     (clk),
        .reset   (reset),
        .issue   (issue),
        .exe     (exe),
        .wb_data (wb_data),
        .wb_addr (wb_addr),
        .wb_en   (wb_en)
    );

endmodule : rv_core_top

`default_nettype wire

// ==== logic/rv_decode.sv ====
// rv_decode: field split, control decode, immediate extension, branch resolve
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_decode (
    input  rv_pkg::instr_t instr,
    input  rv_pkg::word_t  rd1,
    input  rv_pkg::word_t  rd2,
    output rv_pkg::dec_t   dec
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_sel_e   imm_sel;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        dec = '0;
        dec.ra1    = instr[19:15];      // rs1
        dec.ra2    = instr[24:20];      // rs2
        dec.wa3    = instr[11:7];       // rd
        dec.shamt  = instr[24:20];      // same bits as rs2
        dec.alu_op = alu_add;
        dec.wb_sel = wb_alu;
        imm_sel    = imm_i;
        case (opcode)
            `RV_OP_LUI: begin
                dec.we_rf     = 1'b1;
                dec.src_b_imm = 1'b1;
                dec.alu_op    = alu_pass_b; // imm straight through
                imm_sel       = imm_u;
            end
            `RV_OP_IMM: begin
                dec.we_rf     = 1'b1;
                dec.src_b_imm = 1'b1;
                case (funct3)
                    `RV_F3_ADD: dec.alu_op = alu_add;
                    `RV_F3_SLT: dec.alu_op = alu_slt;
                    `RV_F3_XOR: dec.alu_op = alu_xor;
                    `RV_F3_OR:  dec.alu_op = alu_or;
                    `RV_F3_AND: dec.alu_op = alu_and;
                    `RV_F3_SLL: begin
                        dec.alu_op  = alu_sll;
                        dec.illegal = (funct7 != 7'd0);
                    end
                    `RV_F3_SRL: begin
                        dec.alu_op  = alu_srl;
                        dec.illegal = (funct7 != 7'd0); // srai refused
                    end
                    default:    dec.illegal = 1'b1;     // sltiu
                endcase
            end
            `RV_OP_REG: begin
                dec.we_rf = 1'b1;
                if (funct7 == 7'd0) begin
                    case (funct3)
                        `RV_F3_ADD: dec.alu_op = alu_add;
                        `RV_F3_SLT: dec.alu_op = alu_slt;
                        `RV_F3_XOR: dec.alu_op = alu_xor;
                        `RV_F3_OR:  dec.alu_op = alu_or;
                        `RV_F3_AND: dec.alu_op = alu_and;
                        `RV_F3_SLL: dec.alu_op = alu_sll;
                        `RV_F3_SRL: dec.alu_op = alu_srl;
                        default:    dec.illegal = 1'b1; // sltu
                    endcase
                end else if (funct7 == `RV_F7_SUB && funct3 == `RV_F3_ADD) begin
                    dec.alu_op = alu_sub;
                end else begin
                    dec.illegal = 1'b1;     // sra or junk funct7
                end
            end
            `RV_OP_LOAD: begin
                dec.we_rf     = 1'b1;
                dec.src_b_imm = 1'b1;       // rs1 + offset
                dec.wb_sel    = wb_mem;
                dec.illegal   = (funct3 != `RV_F3_LW);
            end
            `RV_OP_STORE: begin
                dec.we_dm     = 1'b1;
                dec.src_b_imm = 1'b1;
                imm_sel       = imm_s;
                dec.illegal   = (funct3 != `RV_F3_SW);
            end
            `RV_OP_BRANCH: begin
                imm_sel = imm_b;
                case (funct3)
                    `RV_F3_BEQ: dec.branch_taken = (rd1 == rd2);
                    `RV_F3_BNE: dec.branch_taken = (rd1 != rd2);
                    default:    dec.illegal      = 1'b1;
                endcase
            end
            default: dec.illegal = 1'b1;    // unsupported opcode
        endcase

        // refused instruction touches nothing
        if (dec.illegal) begin
            dec.we_rf        = 1'b0;
            dec.we_dm        = 1'b0;
            dec.branch_taken = 1'b0;
        end

        case (imm_sel)
            imm_i:   dec.imm = {{20{instr[31]}}, instr[31:20]};
            imm_s:   dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b:   dec.imm = {{19{instr[31]}}, instr[31], instr[7],
                                instr[30:25], instr[11:8], 1'b0};
            default: dec.imm = {instr[31:12], 12'd0};   // u-type
        endcase
    end

endmodule : rv_decode

`default_nettype wire

// ==== logic/rv_execute.sv ====
// rv_execute: operand b select, shift amount select and alu
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  rv_pkg::dec_t  dec,
    input  rv_pkg::word_t rd1,
    input  rv_pkg::word_t rd2,
    output rv_pkg::exe_t  exe
);

    import rv_pkg::*;

    word_t  op_a;
    word_t  op_b;
    shamt_t sh;
    word_t  alu_y;

    assign op_a = rd1;
    assign op_b = dec.src_b_imm ? dec.imm : rd2;        // imm or rs2
    assign sh   = dec.src_b_imm ? dec.shamt : rd2[4:0]; // slli/srli vs sll/srl

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_y = op_a + op_b;
            alu_sub:    alu_y = op_a - op_b;
            alu_slt:    alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_xor:    alu_y = op_a ^ op_b;
            alu_or:     alu_y = op_a | op_b;
            alu_and:    alu_y = op_a & op_b;
            alu_sll:    alu_y = op_a << sh;
            alu_srl:    alu_y = op_a >> sh;     // logical only
            alu_pass_b: alu_y = op_b;
            default:    alu_y = '0;
        endcase
    end

    assign exe.result     = alu_y;
    assign exe.store_data = rd2;                // sw data from rs2
    assign exe.wa3        = dec.wa3;
    assign exe.we_rf      = dec.we_rf;
    assign exe.we_dm      = dec.we_dm;
    assign exe.wb_sel     = dec.wb_sel;

endmodule : rv_execute

`default_nettype wire

// ==== logic/rv_pkg.sv ====
// rv_pkg with datapath typedefs, alu/immediate/write-back enums and stage structs
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;        // datapath word
    typedef logic [31:0] instr_t;       // raw instruction
    typedef logic [4:0]  reg_addr_t;    // register index
    typedef logic [4:0]  shamt_t;       // shift amount

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_pass_b                      // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u
    } imm_sel_e;

    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_sel_e;

    // decode -> execute, apb port
    typedef struct packed {
        reg_addr_t ra1;
        reg_addr_t ra2;
        reg_addr_t wa3;
        word_t     imm;                 // sign extended
        shamt_t    shamt;
        logic      src_b_imm;           // operand b from imm
        alu_op_e   alu_op;
        logic      we_rf;
        logic      we_dm;
        wb_sel_e   wb_sel;
        logic      branch_taken;        // beq/bne resolved
        logic      illegal;
    } dec_t;

    // execute -> result
    typedef struct packed {
        word_t     result;              // alu out, also mem address
        word_t     store_data;
        reg_addr_t wa3;
        logic      we_rf;
        logic      we_dm;
        wb_sel_e   wb_sel;
    } exe_t;

endpackage : rv_pkg

`default_nettype wire

// ==== logic/rv_regfile.sv ====
// rv_regfile: 32 registers with x0 held at zero, two core read ports plus apb read port
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t ra1,
    input  rv_pkg::reg_addr_t ra2,
    input  rv_pkg::reg_addr_t rport,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2,
    output rv_pkg::word_t     rpdata,
    input  rv_pkg::reg_addr_t wa,
    input  logic              we,
    input  rv_pkg::word_t     wd
);

    import rv_pkg::*;

    word_t regs [32];                           // x0 slot cleared by reset only

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin      // writes to x0 dropped here
            regs[wa] <= wd;
        end
    end

    assign rd1    = regs[ra1];
    assign rd2    = regs[ra2];
    assign rpdata = regs[rport];                // apb readback

    // a write aimed at x0 leaves it reading zero on every port next cycle
    x0_stays_zero: assert property (@(posedge clk) disable iff (reset)
        (we && wa == '0) |=> ((ra1 != '0 || rd1 == '0) &&
                              (ra2 != '0 || rd2 == '0) &&
                              (rport != '0 || rpdata == '0)));

endmodule : rv_regfile

`default_nettype wire

// ==== logic/rv_result.sv ====
// rv_result: word data memory and write-back mux
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_result (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  rv_pkg::exe_t      exe,
    output rv_pkg::word_t     wb_data,
    output rv_pkg::reg_addr_t wb_addr,
    output logic              wb_en
);

    import rv_pkg::*;

    localparam int dm_aw = $clog2(`RV_DMEM_WORDS);

    word_t             mem [`RV_DMEM_WORDS];
    logic [dm_aw-1:0]  mem_idx;
    word_t             load_data;

    assign mem_idx   = exe.result[2 +: dm_aw];  // word address, byte offset dropped
    assign load_data = mem[mem_idx];

    // store retires with the issue access
    always_ff @(posedge clk) begin
        if (!reset && issue && exe.we_dm) begin
            mem[mem_idx] <= exe.store_data;
        end
    end

    assign wb_data = (exe.wb_sel == wb_mem) ? load_data : exe.result;
    assign wb_addr = exe.wa3;
    assign wb_en   = issue & exe.we_rf;         // regfile drops x0 itself

endmodule : rv_result

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module rv_core_tb \
    && out="$(./obj_dir/Vrv_core_tb 2>&1)" \
    && printf '%s\n' "$out" \
    && printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/rv_core_tb.sv ====
// rv_core_tb: clock, reset, lfsr stimulus, apb master tasks, isa reference model and checks
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_core_tb;

    import rv_pkg::*;

    localparam int ready_limit = 16;    // cycles allowed for pready

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr;
    int          checks;
    int          errors;

    // isa reference state
    word_t m_regs [32];
    word_t m_mem [16];
    word_t m_pc;
    word_t m_brcnt;

    rv_core_top u_rv_core_top (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #20 clk = ~clk;              // 40 ns period

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("checks %0d, errors %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // one apb transfer, setup then access, sampled at the falling edge
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input word_t data,
                            output word_t rdata, output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wr ? data : '0;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready) begin
            if (waited == ready_limit) begin
                abort_run("pready did not rise within the timeout");
            end
            @(negedge clk);
            waited++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);                 // access ends, instruction retires
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // reference isa step, state changes only when legal
    task automatic model_exec(input instr_t ins, output logic illegal);
        logic [6:0] op;
        logic [6:0] f7;
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      res;
        word_t      ea;
        logic       wr;
        logic       st;
        logic       taken;
        op    = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        rd    = ins[11:7];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        illegal = 1'b0;
        wr      = 1'b0;
        st      = 1'b0;
        taken   = 1'b0;
        res     = '0;
        ea      = '0;
        case (op)
            `RV_OP_LUI: begin
                res = {ins[31:12], 12'd0};
                wr  = 1'b1;
            end
            `RV_OP_IMM: begin
                wr = 1'b1;
                case (f3)
                    3'b000:  res = a + imm_i;
                    3'b010:  res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ imm_i;
                    3'b110:  res = a | imm_i;
                    3'b111:  res = a & imm_i;
                    3'b001:  begin res = a << ins[24:20]; illegal = (f7 != 7'd0); end
                    3'b101:  begin res = a >> ins[24:20]; illegal = (f7 != 7'd0); end
                    default: illegal = 1'b1;            // sltiu
                endcase
            end
            `RV_OP_REG: begin
                wr = 1'b1;
                if (f7 == 7'd0) begin
                    case (f3)
                        3'b000:  res = a + b;
                        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        3'b001:  res = a << b[4:0];
                        3'b101:  res = a >> b[4:0];
                        default: illegal = 1'b1;        // sltu
                    endcase
                end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
                    res = a - b;
                end else begin
                    illegal = 1'b1;
                end
            end
            `RV_OP_LOAD: begin
                ea      = a + imm_i;
                res     = m_mem[ea[5:2]];
                wr      = 1'b1;
                illegal = (f3 != 3'b010);
            end
            `RV_OP_STORE: begin
                ea      = a + imm_s;
                st      = 1'b1;
                illegal = (f3 != 3'b010);
            end
            `RV_OP_BRANCH: begin
                if (f3 == 3'b000) taken = (a == b);
                else if (f3 == 3'b001) taken = (a != b);
                else illegal = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        if (!illegal) begin
            if (wr && rd != 5'd0) m_regs[rd] = res;    // x0 stays zero
            if (st) m_mem[ea[5:2]] = b;
            m_pc = taken ? m_pc + imm_b : m_pc + 32'd4;
            if (taken) m_brcnt = m_brcnt + 32'd1;
        end
    endtask

    task automatic issue_instr(input string name, input instr_t ins, output logic err);
        word_t rdata;
        logic  illegal;
        apb_xfer(1'b1, `RV_ADDR_ISSUE, ins, rdata, err);
        model_exec(ins, illegal);
        check_value({name, " pslverr"}, {31'd0, illegal}, {31'd0, err});
    endtask

    task automatic dump_regs(input string name);
        word_t rdata;
        logic  err;
        for (int i = 0; i < 32; i++) begin
            apb_xfer(1'b0, `RV_ADDR_REG_BASE + 12'(i * 4), '0, rdata, err);
            check_value($sformatf("%s x%0d", name, i), m_regs[i], rdata);
            check_value($sformatf("%s x%0d pslverr", name, i), '0, {31'd0, err});
        end
    endtask

    task automatic check_pc_brcnt(input string name);
        word_t rdata;
        logic  err;
        apb_xfer(1'b0, `RV_ADDR_PC, '0, rdata, err);
        check_value({name, " pc"}, m_pc, rdata);
        check_value({name, " pc pslverr"}, '0, {31'd0, err});
        apb_xfer(1'b0, `RV_ADDR_BRCNT, '0, rdata, err);
        check_value({name, " brcnt"}, m_brcnt, rdata);
        check_value({name, " brcnt pslverr"}, '0, {31'd0, err});
    endtask

    // lui, op-imm or op from the supported subset
    function automatic instr_t rand_alu_instr();
        logic [2:0] kind;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      r;
        kind = 3'(rand_bits(3));
        f3   = 3'(rand_bits(3));
        rd   = reg_addr_t'(rand_bits(5));
        rs1  = reg_addr_t'(rand_bits(5));
        rs2  = reg_addr_t'(rand_bits(5));       // also shamt
        r    = rand_bits(20);
        if (f3 == 3'b011) f3 = `RV_F3_ADD;       // unsigned compare left out
        if (kind == 3'd0) return {r[19:0], rd, `RV_OP_LUI};
        if (kind[0]) begin
            if (f3 == `RV_F3_SLL || f3 == `RV_F3_SRL) begin
                return {7'd0, rs2, rs1, f3, rd, `RV_OP_IMM};
            end
            return {r[11:0], rs1, f3, rd, `RV_OP_IMM};
        end
        f7 = (f3 == `RV_F3_ADD && r[12]) ? `RV_F7_SUB : 7'd0;
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    task automatic run_alu_test();
        logic err;
        for (int n = 1; n <= 300; n++) begin
            issue_instr("alu", rand_alu_instr(), err);
            if (n % 20 == 0) dump_regs("alu");
        end
        check_pc_brcnt("alu");
    endtask

    task automatic run_mem_test();
        logic        err;
        logic [11:0] off;
        reg_addr_t   r5;
        for (int i = 0; i < 16; i++) begin  // fill every word first
            off = 12'(i * 4);
            r5  = reg_addr_t'(rand_bits(5));
            issue_instr("sw fill", {off[11:5], r5, 5'd0, `RV_F3_SW, off[4:0], `RV_OP_STORE}, err);
        end
        for (int n = 0; n < 60; n++) begin
            off = 12'(rand_bits(3) * 4);
            issue_instr("addi base", {off, 5'd0, `RV_F3_ADD, 5'd7, `RV_OP_IMM}, err);
            off = 12'(rand_bits(3) * 4);
            r5  = reg_addr_t'(rand_bits(5));
            if (rand_bits(1) != 0) begin
                issue_instr("sw", {off[11:5], r5, 5'd7, `RV_F3_SW, off[4:0], `RV_OP_STORE}, err);
            end else begin
                issue_instr("lw", {off, 5'd7, `RV_F3_LW, r5, `RV_OP_LOAD}, err);
            end
        end
        dump_regs("mem");
        check_pc_brcnt("mem");
    endtask

    task automatic run_branch_test();
        logic        err;
        logic [12:0] imm;
        logic [2:0]  f3;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        for (int n = 0; n < 40; n++) begin
            imm = {12'(rand_bits(12)), 1'b0};
            f3  = (rand_bits(1) != 0) ? `RV_F3_BNE : `RV_F3_BEQ;
            rs1 = reg_addr_t'(rand_bits(5));
            rs2 = (rand_bits(1) != 0) ? rs1 : reg_addr_t'(rand_bits(5)); // equal half the time
            issue_instr("branch", {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                                   `RV_OP_BRANCH}, err);
            check_pc_brcnt("branch");
        end
    endtask

    task automatic run_fault_test();
        logic       err;
        logic [6:0] op;
        word_t      r;
        word_t      rdata;
        for (int n = 0; n < 10; n++) begin
            r  = rand_bits(25);
            op = 7'(rand_bits(7));
            if (op == `RV_OP_LUI || op == `RV_OP_IMM || op == `RV_OP_REG ||
                op == `RV_OP_LOAD || op == `RV_OP_STORE || op == `RV_OP_BRANCH) begin
                op[0] = 1'b0;                    // every legal opcode ends in 11
            end
            issue_instr("bad opcode", {r[24:0], op}, err);
            check_value("bad opcode fault", 32'd1, {31'd0, err});
        end
        issue_instr("bad funct7", {7'b0000001, 5'd3, 5'd2, `RV_F3_ADD, 5'd1, `RV_OP_REG}, err);
        check_value("bad funct7 fault", 32'd1, {31'd0, err});
        apb_xfer(1'b1, `RV_ADDR_PC, rand_bits(32), rdata, err);
        check_value("pc write fault", 32'd1, {31'd0, err});
        apb_xfer(1'b0, 12'h040, '0, rdata, err);
        check_value("unmapped read fault", 32'd1, {31'd0, err});
        dump_regs("fault");
        check_pc_brcnt("fault");
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr    = 32'd98;
        checks  = 0;
        errors  = 0;
        m_pc    = '0;
        m_brcnt = '0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        for (int i = 0; i < 16; i++) m_mem[i] = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        check_pc_brcnt("reset");
        dump_regs("reset");
        run_alu_test();
        run_mem_test();
        run_branch_test();
        run_fault_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : rv_core_tb

`default_nettype wire
